// ==== Makefile ====
SIM        = verilator
TOP        = id_stage_tb
FLIST      = build.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
LINT_FLAGS = --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
src/rv_isa_pkg.sv
src/id_pipe_pkg.sv
src/id_decoder.sv
src/id_regfile.sv
src/id_operand_fwd.sv
src/id_branch_resolve.sv
src/id_stage.sv
tests/id_stage_props.sv
tests/id_stage_tb.sv

// ==== src/id_branch_resolve.sv ====
////////////////////////////////////////////////////////////
// branch and jump resolution in decode
// condition eval, misprediction check, redirect target
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_branch_resolve (
	input  rv_isa_pkg::uop_e            uop_i,
	input  logic [rv_isa_pkg::XLEN-1:0] imm_i,
	input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
	input  logic [rv_isa_pkg::XLEN-1:0] op1_i,
	input  logic [rv_isa_pkg::XLEN-1:0] op2_i,
	input  logic                        bpu_taken_i,
	output logic                        jump_o,
	output logic [rv_isa_pkg::XLEN-1:0] jump_pc_o
);

	logic eq, lt_s, lt_u;
	logic is_cond;
	logic taken;
	logic [rv_isa_pkg::XLEN-1:0] jalr_sum;

	// compare results
	assign eq   = (op1_i == op2_i);
	assign lt_s = ($signed(op1_i) < $signed(op2_i));
	assign lt_u = (op1_i < op2_i);

	assign is_cond = uop_i inside {rv_isa_pkg::uop_beq, rv_isa_pkg::uop_bne,
		rv_isa_pkg::uop_blt, rv_isa_pkg::uop_bge, rv_isa_pkg::uop_bltu,
		rv_isa_pkg::uop_bgeu};

	always_comb begin
		case (uop_i)
			rv_isa_pkg::uop_beq:  taken = eq;
			rv_isa_pkg::uop_bne:  taken = !eq;
			rv_isa_pkg::uop_blt:  taken = lt_s;
			rv_isa_pkg::uop_bge:  taken = !lt_s;
			rv_isa_pkg::uop_bltu: taken = lt_u;
			rv_isa_pkg::uop_bgeu: taken = !lt_u;
			default:              taken = 1'b0;
		endcase
	end

	// jalr always, jal only if fetch did not predict it,
	// branches when the outcome disagrees with the bpu
	assign jump_o = (uop_i == rv_isa_pkg::uop_jalr)
		|| ((uop_i == rv_isa_pkg::uop_jal) && !bpu_taken_i)
		|| (is_cond && (taken != bpu_taken_i));

	assign jalr_sum = op1_i + imm_i;

	always_comb begin
		if (uop_i == rv_isa_pkg::uop_jalr)
			jump_pc_o = {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0};
		else if (is_cond && bpu_taken_i && !taken)
			// predicted taken but falls through
			jump_pc_o = pc_i + rv_isa_pkg::PC_STEP;
		else
			jump_pc_o = pc_i + imm_i;
	end

endmodule

// ==== src/id_decoder.sv ====
////////////////////////////////////////////////////////////
// instruction decoder
// micro-op select, register enables, immediates
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_decoder (
	input  logic [31:0]           inst_i,
	output id_pipe_pkg::dec_ctl_t ctl_o
);

	rv_isa_pkg::opcode_e opc;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [rv_isa_pkg::XLEN-1:0] imm_i;
	logic [rv_isa_pkg::XLEN-1:0] imm_s;
	logic [rv_isa_pkg::XLEN-1:0] imm_b;
	logic [rv_isa_pkg::XLEN-1:0] imm_u;
	logic [rv_isa_pkg::XLEN-1:0] imm_j;

	assign opc    = rv_isa_pkg::opcode_e'(inst_i[6:0]);
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	// sign-extended immediates, inst[31] is always the sign
	assign imm_i = {{(rv_isa_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{(rv_isa_pkg::XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{(rv_isa_pkg::XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
		inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {{(rv_isa_pkg::XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
	assign imm_j = {{(rv_isa_pkg::XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
		inst_i[20], inst_i[30:21], 1'b0};

	always_comb begin
		// default is a nop with nothing enabled
		ctl_o     = '0;
		ctl_o.uop = rv_isa_pkg::uop_nop;
		ctl_o.rd  = inst_i[11:7];
		case (opc)
			rv_isa_pkg::op_lui: begin
				ctl_o.uop   = rv_isa_pkg::uop_lui;
				ctl_o.rd_en = 1'b1;
				ctl_o.imm   = imm_u;
			end
			rv_isa_pkg::op_jal: begin
				ctl_o.uop   = rv_isa_pkg::uop_jal;
				ctl_o.rd_en = 1'b1;
				ctl_o.imm   = imm_j;
			end
			rv_isa_pkg::op_jalr: begin
				if (funct3 == rv_isa_pkg::F3_ADD) begin
					ctl_o.uop    = rv_isa_pkg::uop_jalr;
					ctl_o.rs1_en = 1'b1;
					ctl_o.rd_en  = 1'b1;
					ctl_o.imm    = imm_i;
				end
			end
			rv_isa_pkg::op_branch: begin
				case (funct3)
					rv_isa_pkg::F3_BEQ:  ctl_o.uop = rv_isa_pkg::uop_beq;
					rv_isa_pkg::F3_BNE:  ctl_o.uop = rv_isa_pkg::uop_bne;
					rv_isa_pkg::F3_BLT:  ctl_o.uop = rv_isa_pkg::uop_blt;
					rv_isa_pkg::F3_BGE:  ctl_o.uop = rv_isa_pkg::uop_bge;
					rv_isa_pkg::F3_BLTU: ctl_o.uop = rv_isa_pkg::uop_bltu;
					rv_isa_pkg::F3_BGEU: ctl_o.uop = rv_isa_pkg::uop_bgeu;
					default:             ctl_o.uop = rv_isa_pkg::uop_nop;
				endcase
				// funct3 010/011 stay a nop
				if (ctl_o.uop != rv_isa_pkg::uop_nop) begin
					ctl_o.rs1_en    = 1'b1;
					ctl_o.rs2_en    = 1'b1;
					ctl_o.is_branch = 1'b1;
					ctl_o.imm       = imm_b;
				end
			end
			rv_isa_pkg::op_load: begin
				// only ld is kept
				if (funct3 == rv_isa_pkg::F3_DW) begin
					ctl_o.uop     = rv_isa_pkg::uop_ld;
					ctl_o.rs1_en  = 1'b1;
					ctl_o.rd_en   = 1'b1;
					ctl_o.is_load = 1'b1;
					ctl_o.imm     = imm_i;
				end
			end
			rv_isa_pkg::op_store: begin
				if (funct3 == rv_isa_pkg::F3_DW) begin
					ctl_o.uop      = rv_isa_pkg::uop_sd;
					ctl_o.rs1_en   = 1'b1;
					ctl_o.rs2_en   = 1'b1;
					ctl_o.is_store = 1'b1;
					ctl_o.imm      = imm_s;
				end
			end
			rv_isa_pkg::op_imm: begin
				if (funct3 == rv_isa_pkg::F3_ADD) begin
					ctl_o.uop    = rv_isa_pkg::uop_addi;
					ctl_o.rs1_en = 1'b1;
					ctl_o.rd_en  = 1'b1;
					ctl_o.imm    = imm_i;
				end
			end
			rv_isa_pkg::op_reg: begin
				case ({funct7, funct3})
					{rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD}: ctl_o.uop = rv_isa_pkg::uop_add;
					{rv_isa_pkg::F7_ALT,  rv_isa_pkg::F3_ADD}: ctl_o.uop = rv_isa_pkg::uop_sub;
					{rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND}: ctl_o.uop = rv_isa_pkg::uop_and;
					{rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR}:  ctl_o.uop = rv_isa_pkg::uop_or;
					{rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR}: ctl_o.uop = rv_isa_pkg::uop_xor;
					default:                                   ctl_o.uop = rv_isa_pkg::uop_nop;
				endcase
				if (ctl_o.uop != rv_isa_pkg::uop_nop) begin
					ctl_o.rs1_en = 1'b1;
					ctl_o.rs2_en = 1'b1;
					ctl_o.rd_en  = 1'b1;
				end
			end
			default: begin
				ctl_o.uop = rv_isa_pkg::uop_nop;
			end
		endcase
		// no writeback to x0, none for stores and branches
		if (ctl_o.rd == '0 || ctl_o.is_branch || ctl_o.is_store) begin
			ctl_o.rd_en = 1'b0;
		end
	end

endmodule

// ==== src/id_operand_fwd.sv ====
////////////////////////////////////////////////////////////
// operand forwarding and load-use detect
// priority ex, ls, wb, then register file
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_operand_fwd (
	input  id_pipe_pkg::dec_ctl_t              ctl_i,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  rs1_i,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  rs2_i,
	input  logic [rv_isa_pkg::XLEN-1:0]        rs1_data_i,
	input  logic [rv_isa_pkg::XLEN-1:0]        rs2_data_i,
	input  id_pipe_pkg::fwd_bus_t              ex_fwd_i,
	input  id_pipe_pkg::fwd_bus_t              ls_fwd_i,
	input  id_pipe_pkg::fwd_bus_t              wb_fwd_i,
	input  logic                               ex_is_load_i,
	output logic [rv_isa_pkg::XLEN-1:0]        op1_o,
	output logic [rv_isa_pkg::XLEN-1:0]        op2_o,
	output logic                               load_use_o
);

	logic ex1_hit, ls1_hit, wb1_hit;
	logic ex2_hit, ls2_hit, wb2_hit;

	// bus carries the enabled, nonzero source register
	function automatic logic bus_hit(id_pipe_pkg::fwd_bus_t bus,
		logic [rv_isa_pkg::REG_ADDR_W-1:0] addr, logic en);
		return bus.valid && en && (addr != '0) && (bus.addr == addr);
	endfunction

	// one operand mux for both sources
	function automatic logic [rv_isa_pkg::XLEN-1:0] sel_op(logic en, logic ex_hit,
		logic ls_hit, logic wb_hit, logic [rv_isa_pkg::XLEN-1:0] rf_data);
		if (!en) return '0;
		// ex data of a load is not ready yet, so it is skipped here
		if (ex_hit && !ex_is_load_i) return ex_fwd_i.data;
		if (ls_hit) return ls_fwd_i.data;
		if (wb_hit) return wb_fwd_i.data;
		return rf_data;
	endfunction

	assign ex1_hit = bus_hit(ex_fwd_i, rs1_i, ctl_i.rs1_en);
	assign ls1_hit = bus_hit(ls_fwd_i, rs1_i, ctl_i.rs1_en);
	assign wb1_hit = bus_hit(wb_fwd_i, rs1_i, ctl_i.rs1_en);
	assign ex2_hit = bus_hit(ex_fwd_i, rs2_i, ctl_i.rs2_en);
	assign ls2_hit = bus_hit(ls_fwd_i, rs2_i, ctl_i.rs2_en);
	assign wb2_hit = bus_hit(wb_fwd_i, rs2_i, ctl_i.rs2_en);

	// bus data read inside sel_op must wake this block too
	always_comb begin
		op1_o = sel_op(ctl_i.rs1_en, ex1_hit, ls1_hit, wb1_hit, rs1_data_i);
		op2_o = sel_op(ctl_i.rs2_en, ex2_hit, ls2_hit, wb2_hit, rs2_data_i);
	end

	// load in ex feeding either source
	assign load_use_o = ex_is_load_i && (ex1_hit || ex2_hit);

endmodule

// ==== src/id_pipe_pkg.sv ====
////////////////////////////////////////////////////////////
// pipeline structs of the decode stage
// forwarding bus, decoder control, id/ex slot
////////////////////////////////////////////////////////////
package id_pipe_pkg;

	// result bus of a later stage, also the regfile write port
	typedef struct packed {
		logic                                 valid;
		logic [rv_isa_pkg::REG_ADDR_W-1:0]    addr;
		logic [rv_isa_pkg::XLEN-1:0]          data;
	} fwd_bus_t;

	// decoder output
	typedef struct packed {
		rv_isa_pkg::uop_e                     uop;
		logic                                 rs1_en;
		logic                                 rs2_en;
		logic                                 rd_en;
		logic [rv_isa_pkg::REG_ADDR_W-1:0]    rd;
		logic                                 is_branch;
		logic                                 is_load;
		logic                                 is_store;
		logic [rv_isa_pkg::XLEN-1:0]          imm;
	} dec_ctl_t;

	// registered id/ex slot
	typedef struct packed {
		logic                                 valid;
		rv_isa_pkg::uop_e                     uop;
		logic [rv_isa_pkg::XLEN-1:0]          op1;
		logic [rv_isa_pkg::XLEN-1:0]          op2;
		logic [rv_isa_pkg::XLEN-1:0]          imm;
		logic [rv_isa_pkg::REG_ADDR_W-1:0]    rd;
		logic                                 rd_en;
		logic                                 is_load;
		logic                                 is_store;
		logic [rv_isa_pkg::XLEN-1:0]          pc;
	} id_ex_t;

endpackage

// ==== src/id_regfile.sv ====
////////////////////////////////////////////////////////////
// 32 x 64 integer register file
// two async reads, one sync write, x0 fixed at zero
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_regfile (
	input  logic                               clk,
	input  logic                               rst_i,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
	input  logic [rv_isa_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
	output logic [rv_isa_pkg::XLEN-1:0]        rs1_data_o,
	output logic [rv_isa_pkg::XLEN-1:0]        rs2_data_o,
	input  id_pipe_pkg::fwd_bus_t              wr_i
);

	logic [rv_isa_pkg::XLEN-1:0] regs [rv_isa_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) regs[i] <= '0;
		end else if (wr_i.valid && wr_i.addr != '0) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	// x0 reads zero regardless of contents
	assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== src/id_stage.sv ====
////////////////////////////////////////////////////////////
// decode stage top
// decoder, regfile, forwarding, branch resolve
// id/ex slot with stall, bubble and back-pressure
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_stage (
	input  logic                        clk,
	input  logic                        rst_i,
	input  logic [31:0]                 inst_i,
	input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
	input  logic                        if_valid_i,
	input  logic                        bpu_taken_i,
	input  id_pipe_pkg::fwd_bus_t       ex_fwd_i,
	input  id_pipe_pkg::fwd_bus_t       ls_fwd_i,
	input  id_pipe_pkg::fwd_bus_t       wb_fwd_i,
	input  logic                        ex_is_load_i,
	input  logic                        ex_ready_i,
	output logic                        id_ready_o,
	output logic                        id_flush_o,
	output logic                        jump_o,
	output logic [rv_isa_pkg::XLEN-1:0] jump_pc_o,
	output id_pipe_pkg::id_ex_t         id_ex_o
);

	id_pipe_pkg::dec_ctl_t ctl;
	logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1, rs2;
	logic [rv_isa_pkg::XLEN-1:0] rs1_data, rs2_data;
	logic [rv_isa_pkg::XLEN-1:0] op1, op2;
	logic load_use;
	logic br_jump;
	logic accept;

	// source fields
	assign rs1 = inst_i[19:15];
	assign rs2 = inst_i[24:20];

	id_decoder u_decoder (
		.inst_i (inst_i),
		.ctl_o  (ctl)
	);

	id_regfile u_regfile (
		.clk        (clk),
		.rst_i      (rst_i),
		.rs1_addr_i (rs1),
		.rs2_addr_i (rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wr_i       (wb_fwd_i)
	);

	id_operand_fwd u_fwd (
		.ctl_i        (ctl),
		.rs1_i        (rs1),
		.rs2_i        (rs2),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.ex_fwd_i     (ex_fwd_i),
		.ls_fwd_i     (ls_fwd_i),
		.wb_fwd_i     (wb_fwd_i),
		.ex_is_load_i (ex_is_load_i),
		.op1_o        (op1),
		.op2_o        (op2),
		.load_use_o   (load_use)
	);

	id_branch_resolve u_branch (
		.uop_i       (ctl.uop),
		.imm_i       (ctl.imm),
		.pc_i        (pc_i),
		.op1_i       (op1),
		.op2_i       (op2),
		.bpu_taken_i (bpu_taken_i),
		.jump_o      (br_jump),
		.jump_pc_o   (jump_pc_o)
	);

	// handshake with fetch
	assign id_ready_o = ex_ready_i && !load_use;
	assign accept     = if_valid_i && id_ready_o;

	// redirect only for an instruction actually taken in
	assign jump_o     = accept && br_jump;
	assign id_flush_o = jump_o;

	// id/ex slot
	always_ff @(posedge clk) begin
		if (rst_i) begin
			id_ex_o <= '0;
		end else if (ex_ready_i) begin
			if (accept) begin
				id_ex_o <= '{valid: 1'b1, uop: ctl.uop, op1: op1, op2: op2,
					imm: ctl.imm, rd: ctl.rd, rd_en: ctl.rd_en,
					is_load: ctl.is_load, is_store: ctl.is_store, pc: pc_i};
			end else begin
				// bubble on load-use or empty fetch
				id_ex_o.valid <= 1'b0;
			end
		end
		// ex_ready_i low holds the slot
	end

endmodule

// ==== src/rv_isa_pkg.sv ====
////////////////////////////////////////////////////////////
// rv64 isa constants for the decode stage
// data width, register file geometry, pc step
// major opcode enum and decoded micro-op enum
// funct3 / funct7 codes of the kept subset
////////////////////////////////////////////////////////////
package rv_isa_pkg;

	// datapath and register file geometry
	localparam int XLEN       = 64;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;

	// fall-through distance of a 32-bit instruction
	localparam logic [XLEN-1:0] PC_STEP = 'd4;

	// major opcodes, inst[6:0]
	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011,
		op_reg    = 7'b0110011
	} opcode_e;

	// decoded micro-ops
	typedef enum logic [4:0] {
		uop_nop,
		uop_add, uop_sub, uop_and, uop_or, uop_xor,
		uop_addi, uop_lui,
		uop_beq, uop_bne, uop_blt, uop_bge, uop_bltu, uop_bgeu,
		uop_jal, uop_jalr,
		uop_ld, uop_sd
	} uop_e;

	// funct3 codes
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;
	localparam logic [2:0] F3_DW   = 3'b011;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	// funct7 codes of the register ops
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

// ==== tests/id_stage_props.sv ====
////////////////////////////////////////////////////////////
// concurrent assertions for id_stage
// reset, flush, stall bubble, back-pressure hold
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_stage_props (
	input logic                clk,
	input logic                rst_i,
	input logic                ex_ready_i,
	input logic                id_ready_o,
	input logic                id_flush_o,
	input logic                jump_o,
	input id_pipe_pkg::id_ex_t id_ex_o
);

	// slot empty right after a reset edge
	a_reset_empty: assert property (@(posedge clk) rst_i |=> !id_ex_o.valid)
		else $error("id_ex_o.valid set after reset");

	// no redirect while held in reset
	a_reset_quiet: assert property (@(posedge clk) rst_i |-> !jump_o && !id_flush_o)
		else $error("jump_o or id_flush_o high during reset");

	a_flush_is_jump: assert property (@(posedge clk) id_flush_o == jump_o)
		else $error("id_flush_o differs from jump_o");

	// load-use stall with ex ready leaves a bubble
	a_stall_bubble: assert property (@(posedge clk) disable iff (rst_i)
		ex_ready_i && !id_ready_o |=> !id_ex_o.valid)
		else $error("stalled slot not cleared");

	// back-pressure freezes the slot
	a_hold: assert property (@(posedge clk) disable iff (rst_i)
		!ex_ready_i |=> $stable(id_ex_o))
		else $error("id_ex_o changed under back-pressure");

endmodule

bind id_stage id_stage_props u_props (
	.clk        (clk),
	.rst_i      (rst_i),
	.ex_ready_i (ex_ready_i),
	.id_ready_o (id_ready_o),
	.id_flush_o (id_flush_o),
	.jump_o     (jump_o),
	.id_ex_o    (id_ex_o)
);

// ==== tests/id_stage_tb.sv ====
////////////////////////////////////////////////////////////
// testbench for the decode stage
// clock, reset, directed and random stimulus
// shadow register file, reference model, compare process
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module id_stage_tb;

	localparam int TIMEOUT  = 50;
	localparam int N_RANDOM = 3000;

	// expected response of one cycle
	typedef struct packed {
		id_pipe_pkg::id_ex_t slot;
		logic                ready;
		logic                jump;
		logic [63:0]         jump_pc;
	} expect_t;

	logic clk = 1'b0;
	logic rst_i;
	logic [31:0] inst_i;
	logic [63:0] pc_i;
	logic if_valid_i, bpu_taken_i, ex_is_load_i, ex_ready_i;
	id_pipe_pkg::fwd_bus_t ex_fwd_i, ls_fwd_i, wb_fwd_i;
	logic id_ready_o, id_flush_o, jump_o;
	logic [63:0] jump_pc_o;
	id_pipe_pkg::id_ex_t id_ex_o;

	// mirror of the register file, written from wb
	logic [63:0] shadow [32];
	int errors = 0;
	int checks = 0;

	id_stage u_id_stage (.*);

	always #20 clk = ~clk;

	// sign-extend the low w bits
	function automatic logic [63:0] sext(logic [63:0] v, int w);
		logic [63:0] sign;
		sign = 64'd1 << (w - 1);
		return (v ^ sign) - sign;
	endfunction

	// operand as seen by decode, ex beats ls beats wb beats regfile
	function automatic logic [63:0] pick_operand(logic en, logic [4:0] src);
		if (!en || src == 5'd0) return 64'd0;
		if (ex_fwd_i.valid && ex_fwd_i.addr == src && !ex_is_load_i) return ex_fwd_i.data;
		if (ls_fwd_i.valid && ls_fwd_i.addr == src) return ls_fwd_i.data;
		if (wb_fwd_i.valid && wb_fwd_i.addr == src) return wb_fwd_i.data;
		return shadow[src];
	endfunction

	// expected outputs for the current inputs, cur is the slot now held
	function automatic expect_t reference(id_pipe_pkg::id_ex_t cur);
		expect_t e;
		rv_isa_pkg::uop_e uop;
		logic [6:0] opc;
		logic [2:0] f3;
		logic [4:0] rs1, rs2, rd;
		logic en1, en2, wen, is_br, taken, stall, redirect, accept;
		logic [63:0] imm, a, b;
		opc = inst_i[6:0];
		f3  = inst_i[14:12];
		rd  = inst_i[11:7];
		rs1 = inst_i[19:15];
		rs2 = inst_i[24:20];
		uop = rv_isa_pkg::uop_nop;
		case (opc)
			7'b0110111: uop = rv_isa_pkg::uop_lui;
			7'b1101111: uop = rv_isa_pkg::uop_jal;
			7'b1100111: if (f3 == 3'd0) uop = rv_isa_pkg::uop_jalr;
			7'b0000011: if (f3 == 3'd3) uop = rv_isa_pkg::uop_ld;
			7'b0100011: if (f3 == 3'd3) uop = rv_isa_pkg::uop_sd;
			7'b0010011: if (f3 == 3'd0) uop = rv_isa_pkg::uop_addi;
			7'b1100011: begin
				case (f3)
					3'd0: uop = rv_isa_pkg::uop_beq;
					3'd1: uop = rv_isa_pkg::uop_bne;
					3'd4: uop = rv_isa_pkg::uop_blt;
					3'd5: uop = rv_isa_pkg::uop_bge;
					3'd6: uop = rv_isa_pkg::uop_bltu;
					3'd7: uop = rv_isa_pkg::uop_bgeu;
					default: uop = rv_isa_pkg::uop_nop;
				endcase
			end
			7'b0110011: begin
				case ({inst_i[31:25], f3})
					10'b0000000_000: uop = rv_isa_pkg::uop_add;
					10'b0100000_000: uop = rv_isa_pkg::uop_sub;
					10'b0000000_111: uop = rv_isa_pkg::uop_and;
					10'b0000000_110: uop = rv_isa_pkg::uop_or;
					10'b0000000_100: uop = rv_isa_pkg::uop_xor;
					default: uop = rv_isa_pkg::uop_nop;
				endcase
			end
			default: uop = rv_isa_pkg::uop_nop;
		endcase
		is_br = uop inside {rv_isa_pkg::uop_beq, rv_isa_pkg::uop_bne, rv_isa_pkg::uop_blt,
			rv_isa_pkg::uop_bge, rv_isa_pkg::uop_bltu, rv_isa_pkg::uop_bgeu};
		// enables and immediate by instruction format
		en1 = !(uop inside {rv_isa_pkg::uop_nop, rv_isa_pkg::uop_lui, rv_isa_pkg::uop_jal});
		en2 = is_br || uop == rv_isa_pkg::uop_sd || uop inside {rv_isa_pkg::uop_add,
			rv_isa_pkg::uop_sub, rv_isa_pkg::uop_and, rv_isa_pkg::uop_or, rv_isa_pkg::uop_xor};
		wen = uop != rv_isa_pkg::uop_nop && uop != rv_isa_pkg::uop_sd && !is_br;
		imm = 64'd0;
		if (uop == rv_isa_pkg::uop_lui) imm = sext({32'd0, inst_i[31:12], 12'd0}, 32);
		if (uop == rv_isa_pkg::uop_jal)
			imm = sext({43'd0, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0}, 21);
		if (uop inside {rv_isa_pkg::uop_jalr, rv_isa_pkg::uop_addi, rv_isa_pkg::uop_ld})
			imm = sext({52'd0, inst_i[31:20]}, 12);
		if (uop == rv_isa_pkg::uop_sd) imm = sext({52'd0, inst_i[31:25], inst_i[11:7]}, 12);
		if (is_br)
			imm = sext({51'd0, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0}, 13);
		a = pick_operand(en1, rs1);
		b = pick_operand(en2, rs2);
		// a load in ex that feeds a source holds decode
		stall = ex_is_load_i && ex_fwd_i.valid && ((en1 && rs1 != 5'd0 && ex_fwd_i.addr == rs1)
			|| (en2 && rs2 != 5'd0 && ex_fwd_i.addr == rs2));
		case (uop)
			rv_isa_pkg::uop_beq:  taken = a == b;
			rv_isa_pkg::uop_bne:  taken = a != b;
			rv_isa_pkg::uop_blt:  taken = $signed(a) < $signed(b);
			rv_isa_pkg::uop_bge:  taken = $signed(a) >= $signed(b);
			rv_isa_pkg::uop_bltu: taken = a < b;
			rv_isa_pkg::uop_bgeu: taken = a >= b;
			default:              taken = 1'b0;
		endcase
		redirect = uop == rv_isa_pkg::uop_jalr || (uop == rv_isa_pkg::uop_jal && !bpu_taken_i)
			|| (is_br && taken != bpu_taken_i);
		if (uop == rv_isa_pkg::uop_jalr) e.jump_pc = (a + imm) & ~64'd1;
		else if (is_br && bpu_taken_i && !taken) e.jump_pc = pc_i + 64'd4;
		else e.jump_pc = pc_i + imm;
		e.ready = ex_ready_i && !stall;
		accept  = if_valid_i && e.ready;
		e.jump  = accept && redirect;
		// next slot contents
		e.slot = cur;
		if (rst_i) begin
			e.slot = '0;
		end else if (ex_ready_i && accept) begin
			e.slot = '{valid: 1'b1, uop: uop, op1: a, op2: b, imm: imm, rd: rd,
				rd_en: wen && rd != 5'd0, is_load: uop == rv_isa_pkg::uop_ld,
				is_store: uop == rv_isa_pkg::uop_sd, pc: pc_i};
		end else if (ex_ready_i) begin
			e.slot.valid = 1'b0;
		end
		return e;
	endfunction

	// empty slots only need valid to match
	task automatic check_slot(id_pipe_pkg::id_ex_t want);
		checks++;
		if (id_ex_o.valid !== want.valid) begin
			errors++;
			$display("ERR %0t: id_ex_o.valid %b, expected %b", $time, id_ex_o.valid, want.valid);
		end else if (want.valid && id_ex_o !== want) begin
			errors++;
			$display("ERR %0t: id_ex_o %h, expected %h", $time, id_ex_o, want);
		end
	endtask

	task automatic check_comb(expect_t want);
		checks++;
		if (id_ready_o !== want.ready) begin
			errors++;
			$display("ERR %0t: id_ready_o %b, expected %b", $time, id_ready_o, want.ready);
		end
		if (jump_o !== want.jump || id_flush_o !== want.jump) begin
			errors++;
			$display("ERR %0t: jump_o %b id_flush_o %b, expected %b", $time, jump_o,
				id_flush_o, want.jump);
		end
		if (want.jump && jump_pc_o !== want.jump_pc) begin
			errors++;
			$display("ERR %0t: jump_pc_o %h, expected %h", $time, jump_pc_o, want.jump_pc);
		end
	endtask

	// follows the regfile write of the edge just passed
	task automatic update_shadow();
		if (rst_i) begin
			for (int i = 0; i < 32; i++) shadow[i] = 64'd0;
		end else if (wb_fwd_i.valid && wb_fwd_i.addr != 5'd0) begin
			shadow[wb_fwd_i.addr] = wb_fwd_i.data;
		end
	endtask

	// compare: slot just after the edge, combinational outputs mid-cycle
	initial begin : compare
		expect_t want;
		id_pipe_pkg::id_ex_t slot_want;
		slot_want = '0;
		@(posedge clk);
		forever begin
			#1;
			check_slot(slot_want);
			update_shadow();
			@(negedge clk);
			want = reference(slot_want);
			check_comb(want);
			slot_want = want.slot;
			@(posedge clk);
		end
	end

	// kind 0..16 is one kept uop each, anything else is raw bits
	function automatic logic [31:0] encode(int kind, logic [4:0] rd, logic [4:0] rs1,
		logic [4:0] rs2, logic [31:0] r);
		logic [2:0] bf3;
		// branch kinds 3..8 map to funct3 0,1,4,5,6,7
		bf3 = 3'(kind - 3);
		if (bf3 >= 3'd2) bf3 = bf3 + 3'd2;
		case (kind)
			0:  return {r[31:12], rd, 7'b0110111};
			1:  return {r[20], r[10:1], r[11], r[19:12], rd, 7'b1101111};
			2:  return {r[11:0], rs1, 3'b000, rd, 7'b1100111};
			3, 4, 5, 6, 7, 8:
				return {r[12], r[10:5], rs2, rs1, bf3, r[4:1], r[11], 7'b1100011};
			9:  return {r[11:0], rs1, 3'b011, rd, 7'b0000011};
			10: return {r[11:5], rs2, rs1, 3'b011, r[4:0], 7'b0100011};
			11: return {r[11:0], rs1, 3'b000, rd, 7'b0010011};
			12: return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
			13: return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
			14: return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
			15: return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
			16: return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
			default: return r;
		endcase
	endfunction

	// small, negative and extreme values so branches go both ways
	function automatic logic [63:0] rand_data();
		case ($urandom % 4)
			0: return 64'($urandom % 4);
			1: return -64'($urandom % 4);
			2: return {$urandom, $urandom};
			default: return 64'h8000_0000_0000_0000 | 64'($urandom % 2);
		endcase
	endfunction

	function automatic id_pipe_pkg::fwd_bus_t rand_bus();
		id_pipe_pkg::fwd_bus_t bus;
		bus.valid = ($urandom % 2) == 0;
		bus.addr  = 5'($urandom % 8);
		bus.data  = rand_data();
		return bus;
	endfunction

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	task automatic clear_buses();
		ex_fwd_i     = '0;
		ls_fwd_i     = '0;
		wb_fwd_i     = '0;
		ex_is_load_i = 1'b0;
	endtask

	// fetch holds inst and pc while decode is not ready
	task automatic drive_random(logic hold);
		if (!hold) begin
			inst_i = encode(int'($urandom % 18), 5'($urandom % 8), 5'($urandom % 8),
				5'($urandom % 8), $urandom);
			pc_i        = {$urandom, $urandom} & ~64'd3;
			if_valid_i  = ($urandom % 8) != 0;
			bpu_taken_i = ($urandom % 2) == 0;
		end
		ex_fwd_i     = rand_bus();
		ls_fwd_i     = rand_bus();
		wb_fwd_i     = rand_bus();
		ex_is_load_i = ($urandom % 4) == 0;
		ex_ready_i   = ($urandom % 8) != 0;
	endtask

	// present one instruction and wait until decode takes it
	task automatic issue(logic [31:0] inst, logic [63:0] pc);
		int n;
		inst_i     = inst;
		pc_i       = pc;
		if_valid_i = 1'b1;
		n = 0;
		@(negedge clk);
		while (!id_ready_o) begin
			n++;
			if (n > TIMEOUT) begin
				$display("timeout: id_ready_o stayed low for %0d cycles", TIMEOUT);
				$display("SIMULATION FAILED");
				$finish;
			end
			@(negedge clk);
		end
		step();
		if_valid_i = 1'b0;
	endtask

	initial begin : stimulus
		logic hold;
		void'($urandom(83));
		rst_i       = 1'b1;
		inst_i      = 32'd0;
		pc_i        = 64'd0;
		if_valid_i  = 1'b0;
		bpu_taken_i = 1'b0;
		ex_ready_i  = 1'b1;
		clear_buses();
		repeat (3) @(posedge clk);
		#2;
		rst_i = 1'b0;

		// fill x1..x7 through wb, then read back, x0 and disabled sources
		for (int i = 1; i < 8; i++) begin
			wb_fwd_i = '{valid: 1'b1, addr: 5'(i), data: rand_data()};
			step();
		end
		clear_buses();
		issue(encode(12, 5'd9, 5'd3, 5'd6, 32'd0), 64'h1000);
		issue(encode(13, 5'd9, 5'd0, 5'd2, 32'd0), 64'h1004);
		issue(encode(0, 5'd4, 5'd0, 5'd0, 32'hfffff123), 64'h1008);

		// same register on all three buses, remove from the top
		ex_fwd_i = '{valid: 1'b1, addr: 5'd5, data: 64'h0eee};
		ls_fwd_i = '{valid: 1'b1, addr: 5'd5, data: 64'h0111};
		wb_fwd_i = '{valid: 1'b1, addr: 5'd5, data: 64'h0222};
		issue(encode(12, 5'd8, 5'd5, 5'd5, 32'd0), 64'h2000);
		ex_fwd_i.valid = 1'b0;
		issue(encode(12, 5'd8, 5'd5, 5'd5, 32'd0), 64'h2004);
		ls_fwd_i.valid = 1'b0;
		issue(encode(12, 5'd8, 5'd5, 5'd5, 32'd0), 64'h2008);
		wb_fwd_i.valid = 1'b0;
		issue(encode(12, 5'd8, 5'd5, 5'd5, 32'd0), 64'h200c);

		// load in ex feeding rs2 for three cycles
		ex_fwd_i     = '{valid: 1'b1, addr: 5'd5, data: rand_data()};
		ex_is_load_i = 1'b1;
		inst_i       = encode(12, 5'd8, 5'd1, 5'd5, 32'd0);
		pc_i         = 64'h3000;
		if_valid_i   = 1'b1;
		repeat (3) begin
			@(negedge clk);
			if (id_ready_o !== 1'b0) begin
				errors++;
				$display("ERR %0t: id_ready_o high during load-use", $time);
			end
			step();
		end
		clear_buses();
		issue(inst_i, pc_i);

		// back-pressure right after a valid slot
		issue(encode(11, 5'd7, 5'd2, 5'd0, 32'h0000_0fff), 64'h3004);
		ex_ready_i = 1'b0;
		if_valid_i = 1'b1;
		repeat (3) step();
		ex_ready_i = 1'b1;
		issue(inst_i, pc_i);

		// random traffic over all uops, buses and predictions
		hold = 1'b0;
		repeat (N_RANDOM) begin
			drive_random(hold);
			@(negedge clk);
			hold = if_valid_i && !id_ready_o;
			step();
		end

		if_valid_i = 1'b0;
		ex_ready_i = 1'b1;
		clear_buses();
		step();
		step();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
